//--- alu.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module alu (
    input  cpu_pkg::data_t    a,
    input  cpu_pkg::data_t    b,
    input  cpu_pkg::alu_op_t  op,
    output cpu_pkg::data_t    result,
    output logic              zero
);
    import cpu_pkg::*;

    // signed view for slt
    logic a_lt_b;

    assign a_lt_b = $signed(a) < $signed(b);

    // --------------------
    // operation select
    // add and sub wrap modulo 256
    always_comb begin
        case (op)
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_SLT: result = {{(`DATA_W-1){1'b0}}, a_lt_b};
            default: result = '0;
        endcase
    end

    // zero flag
    // beq uses it after a subtract
    assign zero = (result == '0);

endmodule

//--- control_unit.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module control_unit (
    input  cpu_pkg::opcode_t  opcode,
    input  cpu_pkg::funct_t   funct,
    output logic              reg_write,
    output logic              reg_dst,
    output logic              alu_src,
    output logic              branch,
    output logic              jump,
    output logic              mem_write,
    output logic              mem_to_reg,
    output cpu_pkg::alu_op_t  alu_op
);
    import cpu_pkg::*;

    // r-type operation from the alu decoder
    alu_op_t rtype_op;
    // funct is one of the five known codes
    logic    rtype_ok;

    // --------------------
    // alu decoder
    always_comb begin
        rtype_ok = 1'b1;
        case (funct)
            `FN_ADD: rtype_op = ALU_ADD;
            `FN_SUB: rtype_op = ALU_SUB;
            `FN_AND: rtype_op = ALU_AND;
            `FN_OR:  rtype_op = ALU_OR;
            `FN_SLT: rtype_op = ALU_SLT;
            default: begin
                rtype_op = ALU_AND;
                rtype_ok = 1'b0;
            end
        endcase
    end

    // --------------------
    // main decoder
    always_comb begin
        // everything inactive unless an opcode matches
        reg_write  = 1'b0;
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        alu_op     = ALU_AND;
        case (opcode)
            `OP_RTYPE: begin
                // unknown funct writes nothing
                reg_write = rtype_ok;
                reg_dst   = 1'b1;
                alu_op    = rtype_op;
            end
            `OP_ADDI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = ALU_ADD;
            end
            `OP_LW: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
                alu_op     = ALU_ADD;
            end
            `OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                alu_op    = ALU_ADD;
            end
            // compare by subtraction, zero flag decides
            `OP_BEQ: begin
                branch = 1'b1;
                alu_op = ALU_SUB;
            end
            `OP_J: begin
                jump = 1'b1;
            end
            default: begin
                reg_write = 1'b0;
            end
        endcase
    end

endmodule

//--- cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// --------------------
// data path sizes
// data and byte address share one width
`define DATA_W      8
`define INSTR_W     32
`define REG_COUNT   8
`define REG_AW      3

// --------------------
// memory sizes
`define IMEM_DEPTH  256
`define DMEM_DEPTH  32
`define DMEM_AW     5

// parallel input and output share one byte address
`define IO_ADDR     8'hFF

// --------------------
// opcodes, bits 31:26
`define OP_RTYPE    6'h00
`define OP_ADDI     6'h08
`define OP_LW       6'h23
`define OP_SW       6'h2B
`define OP_BEQ      6'h04
`define OP_J        6'h02

// funct codes for r-type, bits 5:0
`define FN_ADD      6'h20
`define FN_SUB      6'h22
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2A

`endif

//--- cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

    // --------------------
    // plain vector types

    // data, alu results, pc and immediates
    typedef logic [`DATA_W-1:0] data_t;

    // one instruction word
    typedef logic [`INSTR_W-1:0] instr_t;

    // register index
    // only the low bits of the mips fields are used
    typedef logic [`REG_AW-1:0] reg_addr_t;

    // instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // --------------------
    // alu operations

    // encoding as in the classic mips alu control
    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111
    } alu_op_t;

endpackage

//--- cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    // program load
    input  logic             prog_valid,
    output logic             prog_ready,
    input  cpu_pkg::data_t   prog_addr,
    input  cpu_pkg::instr_t  prog_instr,
    // parallel io
    input  cpu_pkg::data_t   data_in,
    output cpu_pkg::data_t   data_out,
    output cpu_pkg::data_t   pc
);
    import cpu_pkg::*;

    // fetched word and its fields
    instr_t    instr;
    opcode_t   op;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    data_t     imm;

    // controls
    logic    reg_write;
    logic    reg_dst;
    logic    alu_src;
    logic    branch;
    logic    jump;
    logic    mem_write;
    logic    mem_to_reg;
    alu_op_t alu_op;

    // data path
    reg_addr_t wa;
    data_t     rd1;
    data_t     rd2;
    data_t     src_b;
    data_t     alu_result;
    logic      zero;
    data_t     rdata;
    data_t     wd;

    // loading only while the core is stopped
    assign prog_ready = !run;

    // --------------------
    // instruction fields
    assign op    = instr[31:26];
    // low 3 bits of each register field
    assign rs    = instr[23:21];
    assign rt    = instr[18:16];
    assign rd    = instr[13:11];
    assign funct = instr[5:0];
    // immediate, branch offset and jump target share one byte
    assign imm   = instr[7:0];

    // --------------------
    // data path muxes
    assign wa    = reg_dst    ? rd    : rt;
    assign src_b = alu_src    ? imm   : rd2;
    assign wd    = mem_to_reg ? rdata : alu_result;

    // --------------------
    // instances
    program_memory u_imem (
        .clk        (clk),
        .rst        (rst),
        .prog_valid (prog_valid),
        .prog_ready (prog_ready),
        .prog_addr  (prog_addr),
        .prog_instr (prog_instr),
        .fetch_addr (pc),
        .instr      (instr)
    );

    pc_unit u_pc (
        .clk    (clk),
        .rst    (rst),
        .run    (run),
        .branch (branch),
        .jump   (jump),
        .zero   (zero),
        .offset (imm),
        .target (imm),
        .pc     (pc)
    );

    control_unit u_ctrl (
        .opcode     (op),
        .funct      (funct),
        .reg_write  (reg_write),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .branch     (branch),
        .jump       (jump),
        .mem_write  (mem_write),
        .mem_to_reg (mem_to_reg),
        .alu_op     (alu_op)
    );

    register_file u_regs (
        .clk (clk),
        .rst (rst),
        .we  (reg_write),
        .run (run),
        .ra1 (rs),
        .ra2 (rt),
        .wa  (wa),
        .wd  (wd),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    alu u_alu (
        .a      (rd1),
        .b      (src_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    // alu result is the byte address for lw and sw
    data_io u_dmem (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .mem_write (mem_write),
        .addr      (alu_result),
        .wdata     (rd2),
        .data_in   (data_in),
        .rdata     (rdata),
        .data_out  (data_out)
    );

endmodule

//--- data_io.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module data_io (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  logic            mem_write,
    input  cpu_pkg::data_t  addr,
    input  cpu_pkg::data_t  wdata,
    input  cpu_pkg::data_t  data_in,
    output cpu_pkg::data_t  rdata,
    output cpu_pkg::data_t  data_out
);
    import cpu_pkg::*;

    // data ram
    data_t ram [`DMEM_DEPTH];

    // address decode
    logic               is_io;
    logic [`DMEM_AW-1:0] ram_idx;
    logic               ram_we;
    logic               out_we;

    assign is_io   = (addr == `IO_ADDR);
    // ram is aliased over the full byte range
    assign ram_idx = addr[`DMEM_AW-1:0];
    assign ram_we  = run && mem_write && !is_io;
    assign out_we  = run && mem_write && is_io;

    // --------------------
    // ram write
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                ram[i] <= '0;
            end
        end else if (ram_we) begin
            ram[ram_idx] <= wdata;
        end
    end

    // --------------------
    // parallel output register
    always_ff @(posedge clk) begin
        if (rst) begin
            data_out <= '0;
        end else if (out_we) begin
            data_out <= wdata;
        end
    end

    // read path
    // io address returns the parallel input
    assign rdata = is_io ? data_in : ram[ram_idx];

endmodule

//--- pc_unit.sv
`timescale 1ns/10ps

module pc_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  logic            branch,
    input  logic            jump,
    input  logic            zero,
    input  cpu_pkg::data_t  offset,
    input  cpu_pkg::data_t  target,
    output cpu_pkg::data_t  pc
);
    import cpu_pkg::*;

    // sequential and branch addresses
    data_t pc_plus1;
    data_t pc_branch;
    data_t pc_next;

    // --------------------
    // next address
    assign pc_plus1  = pc + 8'd1;
    // taken branch is relative to pc+1
    assign pc_branch = pc_plus1 + offset;

    always_comb begin
        if (jump) begin
            pc_next = target;
        end else if (branch && zero) begin
            pc_next = pc_branch;
        end else begin
            pc_next = pc_plus1;
        end
    end

    // --------------------
    // pc register
    // held at address 0 while the core is stopped
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // a running core always selects a defined next address
    a_next_pc_defined : assert property (
        @(posedge clk) disable iff (rst)
        run |-> !$isunknown(pc_next)
    );

endmodule

//--- program_memory.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module program_memory (
    input  logic             clk,
    input  logic             rst,
    input  logic             prog_valid,
    input  logic             prog_ready,
    input  cpu_pkg::data_t   prog_addr,
    input  cpu_pkg::instr_t  prog_instr,
    input  cpu_pkg::data_t   fetch_addr,
    output cpu_pkg::instr_t  instr
);
    import cpu_pkg::*;

    // instruction storage
    instr_t mem [`IMEM_DEPTH];

    // load handshake
    logic load_fire;

    assign load_fire = prog_valid && prog_ready;

    // --------------------
    // load port
    // all-zero word decodes as an r-type with unknown funct and has no effect
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `IMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (load_fire) begin
            mem[prog_addr] <= prog_instr;
        end
    end

    // --------------------
    // fetch port
    // asynchronous read so the core sees the word in the same cycle
    assign instr = mem[fetch_addr];

    // a load that fires carries a defined address and word
    a_load_defined : assert property (
        @(posedge clk) disable iff (rst)
        load_fire |-> !$isunknown({prog_addr, prog_instr})
    );

endmodule

//--- register_file.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module register_file (
    input  logic                clk,
    input  logic                rst,
    input  logic                we,
    input  logic                run,
    input  cpu_pkg::reg_addr_t  ra1,
    input  cpu_pkg::reg_addr_t  ra2,
    input  cpu_pkg::reg_addr_t  wa,
    input  cpu_pkg::data_t      wd,
    output cpu_pkg::data_t      rd1,
    output cpu_pkg::data_t      rd2
);
    import cpu_pkg::*;

    // register array
    data_t regs [`REG_COUNT];

    // qualified write
    logic wr_en;

    // register 0 is never written
    assign wr_en = we && run && (wa != '0);

    // --------------------
    // write port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wa] <= wd;
        end
    end

    // --------------------
    // read ports
    // combinational reads with register 0 forced to zero
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

    // a qualified write never stores an unknown value
    a_write_defined : assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wd)
    );

endmodule

//--- src.f
+incdir+.
cpu_pkg.sv
program_memory.sv
pc_unit.sv
control_unit.sv
register_file.sv
alu.sv
data_io.sv
cpu_top.sv
tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module tb_cpu;
    import cpu_pkg::*;

    // all tests together take a few hundred cycles
    // limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic    clk;
    logic    rst;
    logic    run;
    logic    prog_valid;
    logic    prog_ready;
    data_t   prog_addr;
    instr_t  prog_instr;
    data_t   data_in;
    data_t   data_out;
    data_t   pc;

    // words that load_program writes into the instruction memory
    instr_t  prog[$];
    int      err_count = 0;
    int      cycle_count = 0;
    integer  seed = 32'h5849;

    cpu_top UUT (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .prog_valid (prog_valid),
        .prog_ready (prog_ready),
        .prog_addr  (prog_addr),
        .prog_instr (prog_instr),
        .data_in    (data_in),
        .data_out   (data_out),
        .pc         (pc)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // --------------------
    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // --------------------
    // instruction encoders in mips field layout
    function automatic instr_t enc_rtype(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    // addi, lw, sw and beq with the immediate in the low byte
    function automatic instr_t enc_itype(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [7:0] imm);
        return {op, rs, rt, 8'h00, imm};
    endfunction

    function automatic instr_t enc_jump(input logic [7:0] target);
        return {`OP_J, 18'd0, target};
    endfunction

    // signed less-than from the sign bits gives 1 or 0
    function automatic data_t slt_ref(input data_t a, input data_t b);
        // operands of opposite sign order by sign alone
        if (a[`DATA_W-1] != b[`DATA_W-1]) begin
            return data_t'(a[`DATA_W-1]);
        end else begin
            return data_t'(a < b);
        end
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
            err_count++;
        end
    endtask

    // one word per accepting edge
    task automatic load_program();
        @(posedge clk);
        for (int i = 0; i < prog.size(); i++) begin
            prog_valid <= 1'b1;
            prog_addr  <= data_t'(i);
            prog_instr <= prog[i];
            @(posedge clk);
            while (!prog_ready) begin
                @(posedge clk);
            end
        end
        prog_valid <= 1'b0;
    endtask

    // n instructions complete before the outputs are sampled mid-cycle
    task automatic run_cycles(input int n);
        @(posedge clk);
        run <= 1'b1;
        repeat (n) @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
    endtask

    // --------------------
    // test 1 covers reset values and the blocked load
    task automatic test_reset_load();
        check("pc", pc, 0);
        check("data_out", data_out, 0);
        check("prog_ready", prog_ready, 1);
        prog.delete();
        prog.push_back(enc_itype(`OP_ADDI, 0, 1, 8'h5A));
        prog.push_back(enc_itype(`OP_SW, 0, 1, `IO_ADDR));
        prog.push_back(enc_jump(8'd2));
        load_program();
        // offer a different first word while the core runs
        @(posedge clk);
        run        <= 1'b1;
        prog_valid <= 1'b1;
        prog_addr  <= 8'd0;
        prog_instr <= enc_itype(`OP_ADDI, 0, 1, 8'h33);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check("prog_ready", prog_ready, 0);
        @(posedge clk);
        run        <= 1'b0;
        prog_valid <= 1'b0;
        // a written word would give 0x33 here
        run_cycles(3);
        check("data_out", data_out, 8'h5A);
        check("pc", pc, 2);
    endtask

    // --------------------
    // test 2 covers arithmetic and logic
    task automatic test_arith();
        data_t a;
        data_t b;
        a = 8'h7D;
        // negative as a signed byte
        b = 8'hC3;
        prog.delete();
        prog.push_back(enc_itype(`OP_ADDI, 0, 1, a));
        prog.push_back(enc_itype(`OP_ADDI, 0, 2, b));
        prog.push_back(enc_rtype(1, 2, 3, `FN_ADD));
        prog.push_back(enc_itype(`OP_SW, 0, 3, `IO_ADDR));
        prog.push_back(enc_rtype(1, 2, 4, `FN_SUB));
        prog.push_back(enc_itype(`OP_SW, 0, 4, `IO_ADDR));
        prog.push_back(enc_rtype(1, 2, 5, `FN_AND));
        prog.push_back(enc_itype(`OP_SW, 0, 5, `IO_ADDR));
        prog.push_back(enc_rtype(1, 2, 6, `FN_OR));
        prog.push_back(enc_itype(`OP_SW, 0, 6, `IO_ADDR));
        prog.push_back(enc_rtype(2, 1, 7, `FN_SLT));
        prog.push_back(enc_itype(`OP_SW, 0, 7, `IO_ADDR));
        prog.push_back(enc_rtype(1, 2, 7, `FN_SLT));
        prog.push_back(enc_itype(`OP_SW, 0, 7, `IO_ADDR));
        // write to r0 and then use it as an operand
        prog.push_back(enc_itype(`OP_ADDI, 0, 0, 8'h55));
        prog.push_back(enc_rtype(0, 1, 3, `FN_ADD));
        prog.push_back(enc_itype(`OP_SW, 0, 3, `IO_ADDR));
        prog.push_back(enc_jump(8'd17));
        load_program();
        // each run stops right after one store
        run_cycles(4);
        check("data_out", data_out, data_t'(a + b));
        run_cycles(6);
        check("data_out", data_out, data_t'(a - b));
        run_cycles(8);
        check("data_out", data_out, a & b);
        run_cycles(10);
        check("data_out", data_out, a | b);
        run_cycles(12);
        check("data_out", data_out, slt_ref(b, a));
        run_cycles(14);
        check("data_out", data_out, slt_ref(a, b));
        run_cycles(17);
        check("data_out", data_out, a);
        run_cycles(20);
        check("pc", pc, 17);
    endtask

    // --------------------
    // test 3 covers the ram round trip
    task automatic test_memory();
        prog.delete();
        prog.push_back(enc_itype(`OP_ADDI, 0, 1, 8'hA5));
        prog.push_back(enc_itype(`OP_ADDI, 0, 2, 8'h3C));
        prog.push_back(enc_itype(`OP_ADDI, 0, 3, 8'hE7));
        // base register for indexed addresses
        prog.push_back(enc_itype(`OP_ADDI, 0, 7, 8'd2));
        prog.push_back(enc_itype(`OP_SW, 0, 1, 8'd3));
        prog.push_back(enc_itype(`OP_SW, 7, 2, 8'd8));
        prog.push_back(enc_itype(`OP_SW, 0, 3, 8'd30));
        prog.push_back(enc_itype(`OP_LW, 0, 4, 8'd3));
        prog.push_back(enc_itype(`OP_SW, 0, 4, `IO_ADDR));
        prog.push_back(enc_itype(`OP_LW, 0, 5, 8'd10));
        prog.push_back(enc_itype(`OP_SW, 0, 5, `IO_ADDR));
        prog.push_back(enc_itype(`OP_LW, 7, 6, 8'd28));
        prog.push_back(enc_itype(`OP_SW, 0, 6, `IO_ADDR));
        prog.push_back(enc_jump(8'd13));
        load_program();
        run_cycles(9);
        check("data_out", data_out, 8'hA5);
        run_cycles(11);
        check("data_out", data_out, 8'h3C);
        run_cycles(13);
        check("data_out", data_out, 8'hE7);
    endtask

    // --------------------
    // test 4 covers branches and the jump
    task automatic test_branch();
        prog.delete();
        prog.push_back(enc_itype(`OP_ADDI, 0, 1, 8'd5));
        prog.push_back(enc_itype(`OP_ADDI, 0, 2, 8'd5));
        prog.push_back(enc_itype(`OP_ADDI, 0, 3, 8'd9));
        // equal operands skip word 4
        prog.push_back(enc_itype(`OP_BEQ, 1, 2, 8'd1));
        prog.push_back(enc_itype(`OP_ADDI, 0, 4, 8'h11));
        prog.push_back(enc_itype(`OP_ADDI, 0, 4, 8'h22));
        // unequal operands fall through
        prog.push_back(enc_itype(`OP_BEQ, 1, 3, 8'd1));
        prog.push_back(enc_itype(`OP_ADDI, 4, 4, 8'd1));
        prog.push_back(enc_jump(8'd11));
        prog.push_back(enc_itype(`OP_ADDI, 0, 4, 8'h77));
        prog.push_back(enc_itype(`OP_ADDI, 0, 4, 8'h78));
        prog.push_back(enc_itype(`OP_SW, 0, 4, `IO_ADDR));
        prog.push_back(enc_jump(8'd12));
        load_program();
        // trace 0 1 2 3 5 6 7 8 11 12
        run_cycles(4);
        check("pc", pc, 5);
        run_cycles(6);
        check("pc", pc, 7);
        run_cycles(8);
        check("pc", pc, 11);
        run_cycles(9);
        check("pc", pc, 12);
        check("data_out", data_out, 8'h23);
        run_cycles(11);
        check("pc", pc, 12);
    endtask

    // --------------------
    // test 5 covers parallel input with random bytes
    task automatic test_input();
        data_t in_val;
        data_t imm_val;
        for (int n = 0; n < 4; n++) begin
            in_val  = data_t'($random(seed));
            imm_val = data_t'($random(seed));
            prog.delete();
            prog.push_back(enc_itype(`OP_LW, 0, 1, `IO_ADDR));
            prog.push_back(enc_itype(`OP_ADDI, 1, 2, imm_val));
            prog.push_back(enc_itype(`OP_SW, 0, 2, `IO_ADDR));
            prog.push_back(enc_jump(8'd3));
            load_program();
            @(posedge clk);
            data_in <= in_val;
            run_cycles(3);
            check("data_out", data_out, data_t'(in_val + imm_val));
        end
    endtask

    // --------------------
    // main sequence
    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        run        = 1'b0;
        prog_valid = 1'b0;
        prog_addr  = '0;
        prog_instr = '0;
        data_in    = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_reset_load();
        test_arith();
        test_memory();
        test_branch();
        test_input();
        $display("errors: %0d", err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
